//--- testbench/remote_req_input.txt
// columns: eva tgo_x tgo_y dram_en gap exp_x exp_y exp_epa flag, all hex
// flag 0 forwarded, 1 invalid, 2 dropped on overflow, f ends the list
// global, fields straight from the eva
420C048C 0 0 0 2 3 2 0000123 0
452BFFFC 0 0 0 1 A 5 000FFFF 0
40000000 3 3 1 2 0 0 0000000 0  // origin not used
// tile-group, origin added
21080100 1 2 0 2 3 3 0000040 0
230C48D0 2 1 0 3 5 4 0001234 0
2F380020 3 3 0 2 1 2 0000008 0  // coordinates wrap
// tile-group shared, dmem base 400
08000000 0 0 0 2 0 0 0000400 0
08000ACC 1 2 0 2 3 3 000042B 0
0FFFFFFC 1 1 0 1 4 4 02003FF 0
08002134 0 0 0 2 1 2 0000485 0
// striped dram, eight lines walk all banks
80000000 0 0 1 2 0 0 0000000 0
80000024 0 0 1 2 1 0 0000001 0
80000048 0 0 1 1 2 0 0000002 0
8000006C 0 0 1 2 3 0 0000003 0
80000090 0 0 1 2 0 F 0000004 0  // bottom row from here
800000B4 0 0 1 2 1 F 0000005 0
800000D8 0 0 1 3 2 F 0000006 0
800000FC 0 0 1 2 3 F 0000007 0
80000100 0 0 1 2 0 0 0000008 0  // bank 0 again, index 1
ABCDE124 0 0 1 2 1 0 15E6F09 0
FFFFFFFC 0 0 1 2 3 F 3FFFFFF 0
// dram mode off, vcache blocks
80000000 0 0 0 2 0 0 0000000 0
80003694 0 0 0 2 2 F 00001A5 0
80001FFC 0 0 0 2 3 0 00001FF 0
80FF0804 0 0 0 2 1 0 0000001 0
// host dram, bit 30 set
C0000000 0 0 0 2 0 1 8000000 0
C0001234 0 0 0 2 0 1 800048D 0
DFFFFFFC 0 0 0 2 0 1 FFFFFFF 0
E0000010 0 0 0 2 0 1 8000004 0
// invalid addresses between valid ones
00000000 0 0 0 2 0 0 0000000 1
420C048C 0 0 0 1 3 2 0000123 0
07FFFFFC 0 0 1 2 0 0 0000000 1
08000ACC 1 2 0 2 3 3 000042B 0
04000000 0 0 0 1 0 0 0000000 1
00001234 2 2 1 2 0 0 0000000 1
80000024 0 0 1 C 1 0 0000001 0  // long gap drains the fifo
// burst every cycle, ninth strobe finds the fifo full
41040000 0 0 0 0 1 1 0000000 0
41040004 0 0 0 0 1 1 0000001 0
41040008 0 0 0 0 1 1 0000002 0
4104000C 0 0 0 0 1 1 0000003 0
41040010 0 0 0 0 1 1 0000004 0
41040014 0 0 0 0 1 1 0000005 0
41040018 0 0 0 0 1 1 0000006 0
4104001C 0 0 0 0 1 1 0000007 0
41040020 0 0 0 A 1 1 0000008 2
// after the drop
02000000 0 0 0 2 0 0 0000000 1
C0001234 0 0 0 3 0 1 800048D 0
00000000 0 0 0 0 0 0 0000000 F

//--- tb.f
+incdir+include
verilog/manycore_addr_pkg.sv
verilog/manycore_link_pkg.sv
verilog/manycore_dram_hash.sv
verilog/manycore_eva_to_npa.sv
verilog/manycore_npa_fifo.sv
verilog/manycore_link_serializer.sv
verilog/manycore_remote_req_top.sv
testbench/tb_remote_req.sv

//--- testbench/tb_remote_req.sv
`timescale 1ns/1ns
`include "manycore_defines.svh"

// remote request path testbench
// vectors come from remote_req_input.txt, packets are rebuilt from the link
module tb_remote_req;

  localparam int words_per_vec_lp = 9;   // columns per line of the input file
  localparam int max_vecs_lp      = 64;
  localparam int head_epa_w_lp    = `MC_ADDR_WIDTH - `MC_FLIT_WIDTH;  // 10

  logic                          clk;
  logic                          rst_n;
  logic                          req_v;
  logic [`MC_DATA_WIDTH-1:0]     eva;
  logic [`MC_X_CORD_WIDTH-1:0]   tgo_x;
  logic [`MC_Y_CORD_WIDTH-1:0]   tgo_y;
  logic                          dram_enable;
  logic                          invalid;
  logic                          full;
  logic                          overflow;
  logic                          link_v;
  logic [`MC_FLIT_WIDTH-1:0]     link_flit;

  logic [31:0] vec_mem [0:words_per_vec_lp*max_vecs_lp-1];
  logic [35:0] exp_q [$];   // {x, y, epa} in request order
  string       name_q [$];

  int          errors = 0;
  int          packets_seen = 0;
  int          nvec;
  int          cycle_count = 0;
  int          cycle_limit = 1000;  // replaced once the file is read
  int          base;
  int          gap;
  int          extra;
  int          flag;
  int unsigned seed_val;
  string       name;

  // link reassembly
  logic                        in_tail = 1'b0;
  logic [`MC_FLIT_WIDTH-1:0]   head_flit;
  logic [`MC_X_CORD_WIDTH-1:0] got_x;
  logic [`MC_Y_CORD_WIDTH-1:0] got_y;
  logic [`MC_ADDR_WIDTH-1:0]   got_epa;
  logic [35:0]                 exp_pkt;
  string                       pkt_name;

  manycore_remote_req_top u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_v_i       (req_v),
    .eva_i         (eva),
    .tgo_x_i       (tgo_x),
    .tgo_y_i       (tgo_y),
    .dram_enable_i (dram_enable),
    .invalid_o     (invalid),
    .full_o        (full),
    .overflow_o    (overflow),
    .link_v_o      (link_v),
    .link_flit_o   (link_flit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  // address region, used only to name a vector in messages
  function automatic string region_label(input logic [31:0] addr, input logic dram_on);
    string label;
    if (addr[31]) label = dram_on ? "dram" : (addr[30] ? "host" : "vcache");
    else if (addr[30]) label = "global";
    else if (addr[29]) label = "tile_group";
    else if (addr[28:27] == 2'b01) label = "shared";
    else label = "invalid";
    return label;
  endfunction

  initial begin
    req_v       = 1'b0;
    eva         = '0;
    tgo_x       = '0;
    tgo_y       = '0;
    dram_enable = 1'b0;
    rst_n       = 1'b0;
    seed_val    = $urandom(58324);
    $readmemh("testbench/remote_req_input.txt", vec_mem);
    nvec = 0;
    while (nvec < max_vecs_lp &&
           vec_mem[nvec*words_per_vec_lp+8] !== 32'hf) begin  // flag f ends
      nvec++;
    end
    if (nvec == 0) begin
      errors++;
      $display("no vectors were read from the input file");
    end
    cycle_limit = nvec*8 + 100;

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (invalid !== 1'b0 || overflow !== 1'b0 || full !== 1'b0 || link_v !== 1'b0) begin
      errors++;
      $display("outputs not idle after reset");
    end

    for (int i = 0; i < nvec; i++) begin
      base = i*words_per_vec_lp;
      gap  = vec_mem[base+4];
      flag = vec_mem[base+8];  // 0 forwarded, 1 invalid, 2 dropped
      name = $sformatf("vec%0d_%s", i, region_label(vec_mem[base], vec_mem[base+3][0]));
      if (flag == 2 && full !== 1'b1) begin  // drop strobe is meant to hit a full fifo
        errors++;
        $display("FAILED %s full expected 1 actual %b", name, full);
      end
      eva         = vec_mem[base];
      tgo_x       = vec_mem[base+1][`MC_X_CORD_WIDTH-1:0];
      tgo_y       = vec_mem[base+2][`MC_Y_CORD_WIDTH-1:0];
      dram_enable = vec_mem[base+3][0];
      req_v       = 1'b1;
      if (flag == 0) begin
        exp_q.push_back({vec_mem[base+5][3:0], vec_mem[base+6][3:0], vec_mem[base+7][27:0]});
        name_q.push_back(name);
      end
      @(negedge clk);
      req_v = 1'b0;
      // one cycle after the strobe
      if (invalid !== (flag == 1)) begin
        errors++;
        $display("FAILED %s invalid expected %0d actual %b", name, flag == 1, invalid);
      end
      if (overflow !== (flag == 2)) begin
        errors++;
        $display("FAILED %s overflow expected %0d actual %b", name, flag == 2, overflow);
      end
      extra = (gap != 0) ? $urandom % 4 : 0;  // burst lines keep gap 0
      repeat (gap + extra) @(negedge clk);
    end

    while (exp_q.size() != 0) @(negedge clk);
    repeat (10) @(negedge clk);  // room for stray flits
    $display("errors %0d, packets checked %0d, packets missing %0d",
             errors, packets_seen, exp_q.size());
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // head then tail, back to back on link_v
  always @(negedge clk) begin
    if (rst_n && link_v) begin
      if (!in_tail) begin
        head_flit = link_flit;
        in_tail   = 1'b1;
      end else begin
        in_tail = 1'b0;
        got_x   = head_flit[`MC_FLIT_WIDTH-1 -: `MC_X_CORD_WIDTH];
        got_y   = head_flit[head_epa_w_lp +: `MC_Y_CORD_WIDTH];
        got_epa = {head_flit[head_epa_w_lp-1:0], link_flit};
        if (exp_q.size() == 0) begin
          errors++;
          $display("link packet x %h y %h epa %h arrived with no request outstanding",
                   got_x, got_y, got_epa);
        end else begin
          exp_pkt  = exp_q.pop_front();
          pkt_name = name_q.pop_front();
          packets_seen++;
          if (got_x !== exp_pkt[35:32]) begin
            errors++;
            $display("FAILED %s x expected %h actual %h", pkt_name, exp_pkt[35:32], got_x);
          end
          if (got_y !== exp_pkt[31:28]) begin
            errors++;
            $display("FAILED %s y expected %h actual %h", pkt_name, exp_pkt[31:28], got_y);
          end
          if (got_epa !== exp_pkt[27:0]) begin
            errors++;
            $display("FAILED %s epa expected %h actual %h", pkt_name, exp_pkt[27:0], got_epa);
          end
        end
      end
    end
  end

  // run limit from the vector count
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d packets still missing",
               cycle_count, exp_q.size());
      $display("errors %0d, packets checked %0d", errors, packets_seen);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

//--- verilog/manycore_remote_req_top.sv
`timescale 1ns/1ns
`include "manycore_defines.svh"

// remote request address path
// translate, buffer, serialize
module manycore_remote_req_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_v_i,
  input  manycore_addr_pkg::eva_t    eva_i,
  input  manycore_addr_pkg::x_cord_t tgo_x_i,
  input  manycore_addr_pkg::y_cord_t tgo_y_i,
  input  logic                       dram_enable_i,
  output logic                       invalid_o,
  output logic                       full_o,
  output logic                       overflow_o,
  output logic                       link_v_o,
  output manycore_link_pkg::flit_t   link_flit_o
);
  import manycore_addr_pkg::*;

  // producer to fifo
  logic    npa_v;
  x_cord_t npa_x;
  y_cord_t npa_y;
  epa_t    npa_epa;

  // fifo to consumer
  logic    empty;
  logic    pop;
  x_cord_t head_x;
  y_cord_t head_y;
  epa_t    head_epa;

  manycore_eva_to_npa u_eva_to_npa (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_v_i       (req_v_i),
    .eva_i         (eva_i),
    .tgo_x_i       (tgo_x_i),
    .tgo_y_i       (tgo_y_i),
    .dram_enable_i (dram_enable_i),
    .npa_v_o       (npa_v),
    .npa_x_o       (npa_x),
    .npa_y_o       (npa_y),
    .npa_epa_o     (npa_epa),
    .invalid_o     (invalid_o)
  );

  manycore_npa_fifo u_npa_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_v_i     (npa_v),
    .wr_x_i     (npa_x),
    .wr_y_i     (npa_y),
    .wr_epa_i   (npa_epa),
    .pop_i      (pop),
    .head_x_o   (head_x),
    .head_y_o   (head_y),
    .head_epa_o (head_epa),
    .empty_o    (empty),
    .full_o     (full_o),
    .overflow_o (overflow_o)
  );

  manycore_link_serializer u_link_serializer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .empty_i     (empty),
    .head_x_i    (head_x),
    .head_y_i    (head_y),
    .head_epa_i  (head_epa),
    .pop_o       (pop),
    .link_v_o    (link_v_o),
    .link_flit_o (link_flit_o)
  );

endmodule

//--- verilog/manycore_link_serializer.sv
`timescale 1ns/1ns
`include "manycore_defines.svh"

// drains the fifo onto the 18 bit link, two flits per npa
// back to back packets pop straight from SER_TAIL
module manycore_link_serializer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       empty_i,
  input  manycore_addr_pkg::x_cord_t head_x_i,
  input  manycore_addr_pkg::y_cord_t head_y_i,
  input  manycore_addr_pkg::epa_t    head_epa_i,
  output logic                       pop_o,
  output logic                       link_v_o,
  output manycore_link_pkg::flit_t   link_flit_o
);
  import manycore_addr_pkg::*;
  import manycore_link_pkg::*;

  localparam int tail_w_lp = `MC_FLIT_WIDTH;                  // epa bits in the tail
  localparam int head_epa_w_lp = `MC_ADDR_WIDTH - tail_w_lp;  // epa bits in the head

  ser_state_e state, state_next;

  logic [tail_w_lp-1:0] tail_q;  // low epa bits of the popped entry
  flit_t                head_flit;

  // x, y, then upper epa bits
  assign head_flit = {head_x_i, head_y_i, head_epa_i[`MC_ADDR_WIDTH-1 -: head_epa_w_lp]};

  // take a new entry when the link is free next cycle
  assign pop_o = (state == SER_IDLE || state == SER_TAIL) & ~empty_i;

  always_comb begin
    state_next = state;
    case (state)
      SER_IDLE: if (!empty_i) state_next = SER_HEAD;
      SER_HEAD: state_next = SER_TAIL;
      SER_TAIL: state_next = empty_i ? SER_IDLE : SER_HEAD;
      default:  state_next = SER_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state    <= SER_IDLE;
      link_v_o <= 1'b0;
    end else begin
      state    <= state_next;
      link_v_o <= (state_next != SER_IDLE);  // valid on head and tail
    end
  end

  // flit payload
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      link_flit_o <= head_flit;                 // head next cycle
      tail_q      <= head_epa_i[tail_w_lp-1:0];  // kept for the tail
    end else if (state == SER_HEAD) begin
      link_flit_o <= flit_t'(tail_q);
    end
  end

endmodule

//--- verilog/manycore_npa_fifo.sv
`timescale 1ns/1ns
`include "manycore_defines.svh"

// small circular buffer between translation and the link
// head entry shows combinationally while not empty
module manycore_npa_fifo (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       wr_v_i,
  input  manycore_addr_pkg::x_cord_t wr_x_i,
  input  manycore_addr_pkg::y_cord_t wr_y_i,
  input  manycore_addr_pkg::epa_t    wr_epa_i,
  input  logic                       pop_i,       // only while not empty
  output manycore_addr_pkg::x_cord_t head_x_o,
  output manycore_addr_pkg::y_cord_t head_y_o,
  output manycore_addr_pkg::epa_t    head_epa_o,
  output logic                       empty_o,
  output logic                       full_o,      // level, requester holds off
  output logic                       overflow_o   // refused write
);
  import manycore_addr_pkg::*;

  localparam int depth_lp = `MC_FIFO_DEPTH;
  localparam int ptr_w_lp = $clog2(depth_lp);
  localparam int cnt_w_lp = $clog2(depth_lp+1);

  x_cord_t x_mem   [depth_lp];
  y_cord_t y_mem   [depth_lp];
  epa_t    epa_mem [depth_lp];

  logic [ptr_w_lp-1:0] wr_ptr, rd_ptr;
  logic [cnt_w_lp-1:0] count;
  logic                wr_accept;
  logic                rd_fire;

  assign full_o  = count == cnt_w_lp'(depth_lp);
  assign empty_o = count == '0;

  assign rd_fire    = pop_i & ~empty_o;
  assign wr_accept  = wr_v_i & (~full_o | rd_fire);  // pop frees a slot this cycle
  assign overflow_o = wr_v_i & ~wr_accept;           // entry dropped

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_accept) begin
        wr_ptr <= (wr_ptr == ptr_w_lp'(depth_lp-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_fire) begin
        rd_ptr <= (rd_ptr == ptr_w_lp'(depth_lp-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_accept, rd_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      x_mem[wr_ptr]   <= wr_x_i;
      y_mem[wr_ptr]   <= wr_y_i;
      epa_mem[wr_ptr] <= wr_epa_i;
    end
  end

  assign head_x_o   = x_mem[rd_ptr];
  assign head_y_o   = y_mem[rd_ptr];
  assign head_epa_o = epa_mem[rd_ptr];

endmodule

//--- verilog/manycore_eva_to_npa.sv
`timescale 1ns/1ns
`include "manycore_defines.svh"

// eva to npa translation for the universal regions
// dram, global, tile-group and tile-group shared
// one cycle from strobe to registered npa or invalid pulse
module manycore_eva_to_npa (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_v_i,        // single cycle strobe
  input  manycore_addr_pkg::eva_t    eva_i,          // byte address
  input  manycore_addr_pkg::x_cord_t tgo_x_i,        // tile-group origin x
  input  manycore_addr_pkg::y_cord_t tgo_y_i,        // tile-group origin y
  input  logic                       dram_enable_i,  // striped dram mode
  output logic                       npa_v_o,
  output manycore_addr_pkg::x_cord_t npa_x_o,
  output manycore_addr_pkg::y_cord_t npa_y_o,
  output manycore_addr_pkg::epa_t    npa_epa_o,
  output logic                       invalid_o
);
  import manycore_addr_pkg::*;

  localparam int offset_w_lp   = `MC_BLOCK_OFFSET_WIDTH;        // word in block
  localparam int lg_vc_size_lp = $clog2(`MC_VCACHE_SIZE_WORDS); // word in vcache
  localparam int lg_tiles_x_lp = $clog2(`MC_NUM_TILES_X);
  localparam int bank_bits_lp  = `MC_HASH_BANK_BITS;
  localparam int tg_x_w_lp     = $clog2(`MC_TG_DIM);
  localparam int tg_y_w_lp     = $clog2(`MC_TG_DIM);
  localparam int stripe_w_lp   = $clog2(`MC_STRIPE_WORDS);
  localparam int sh_addr_w_lp  = `MC_DATA_WIDTH-5-tg_y_w_lp-tg_x_w_lp-stripe_w_lp-2;
  localparam int sh_x_lsb_lp   = 2+stripe_w_lp;
  localparam int sh_y_lsb_lp   = sh_x_lsb_lp+tg_x_w_lp;
  localparam int sh_addr_lsb_lp = sh_y_lsb_lp+tg_y_w_lp;

  // region decode
  logic is_dram, is_global, is_tile_group, is_shared, is_invalid;

  assign is_dram       = eva_i[31];
  assign is_global     = eva_i[31:30] == 2'b01;
  assign is_tile_group = eva_i[31:29] == 3'b001;
  assign is_shared     = eva_i[31:27] == 5'b00001;
  assign is_invalid    = ~(is_dram | is_global | is_tile_group | is_shared);

  // dram line hash
  hash_input_t hash_in;
  hash_bank_t  hash_bank;
  hash_index_t hash_index;

  assign hash_in = eva_i[2+offset_w_lp +: `MC_HASH_INPUT_WIDTH];  // eva[30:5]

  manycore_dram_hash u_dram_hash (
    .hash_i  (hash_in),
    .bank_o  (hash_bank),
    .index_o (hash_index)
  );

  // shared address fields
  logic [sh_addr_w_lp-1:0] sh_addr;
  logic [tg_y_w_lp-1:0]    sh_y;
  logic [tg_x_w_lp-1:0]    sh_x;
  logic [stripe_w_lp-1:0]  sh_stripe;

  assign sh_stripe = eva_i[2 +: stripe_w_lp];
  assign sh_x      = eva_i[sh_x_lsb_lp +: tg_x_w_lp];
  assign sh_y      = eva_i[sh_y_lsb_lp +: tg_y_w_lp];
  assign sh_addr   = eva_i[sh_addr_lsb_lp +: sh_addr_w_lp];

  x_cord_t x_next;
  y_cord_t y_next;
  epa_t    epa_next;

  always_comb begin
    x_next   = '0;
    y_next   = '0;
    epa_next = '0;
    if (is_dram) begin
      if (dram_enable_i) begin
        // striped over all banks, bottom flag picks y max
        y_next   = hash_bank[bank_bits_lp-1] ? '1 : '0;
        x_next   = x_cord_t'(hash_bank[bank_bits_lp-2:0]);
        epa_next = epa_t'({hash_index, eva_i[2 +: offset_w_lp]});
      end else if (eva_i[30]) begin
        // host memory behind the io tile
        y_next   = y_cord_t'(1);
        x_next   = '0;
        epa_next = {1'b1, eva_i[2 +: `MC_ADDR_WIDTH-1]};
      end else begin
        // vcache as plain block memory
        y_next   = eva_i[2+lg_vc_size_lp+lg_tiles_x_lp] ? '1 : '0;
        x_next   = x_cord_t'(eva_i[2+lg_vc_size_lp +: lg_tiles_x_lp]);
        epa_next = epa_t'(eva_i[2 +: lg_vc_size_lp]);
      end
    end else if (is_global) begin
      // {01, y[29:24], x[23:18], addr[17:2]}
      y_next   = y_cord_t'(eva_i[29:24]);
      x_next   = x_cord_t'(eva_i[23:18]);
      epa_next = epa_t'(eva_i[17:2]);
    end else if (is_tile_group) begin
      // {001, y[28:24], x[23:18], addr[17:2]}, relative to origin
      y_next   = y_cord_t'(eva_i[28:24]) + tgo_y_i;
      x_next   = x_cord_t'(eva_i[23:18]) + tgo_x_i;
      epa_next = epa_t'(eva_i[17:2]);
    end else if (is_shared) begin
      y_next   = y_cord_t'(sh_y) + tgo_y_i;
      x_next   = x_cord_t'(sh_x) + tgo_x_i;
      epa_next = epa_t'({sh_addr, sh_stripe}) + epa_t'(`MC_DMEM_BASE);  // offset into dmem
    end
  end

  // strobe outputs
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      npa_v_o   <= 1'b0;
      invalid_o <= 1'b0;
    end else begin
      npa_v_o   <= req_v_i & ~is_invalid;
      invalid_o <= req_v_i & is_invalid;  // no npa for these
    end
  end

  // npa payload, held until the next strobe
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      npa_x_o   <= x_next;
      npa_y_o   <= y_next;
      npa_epa_o <= epa_next;
    end
  end

endmodule

//--- verilog/manycore_dram_hash.sv
`timescale 1ns/1ns
`include "manycore_defines.svh"

// bank striping of dram lines over the vcaches
// consecutive lines walk the top row first, then the bottom row
module manycore_dram_hash (
  input  manycore_addr_pkg::hash_input_t hash_i,   // dram line address
  output manycore_addr_pkg::hash_bank_t  bank_o,   // {bottom_not_top, x}
  output manycore_addr_pkg::hash_index_t index_o   // line index within the bank
);
  import manycore_addr_pkg::*;

  localparam int bank_bits_lp  = `MC_HASH_BANK_BITS;    // 3 for 8 banks
  localparam int input_width_lp = `MC_HASH_INPUT_WIDTH;

  logic [bank_bits_lp-1:0] bank_num;  // raw bank number 0..7

  // low line bits pick the bank, power of two bank count
  assign bank_num = hash_i[bank_bits_lp-1:0];

  // upper bank bit becomes the bottom row flag
  // bit 3 of bank_o stays zero
  assign bank_o = hash_bank_t'(bank_num);

  // remaining line bits index the bank
  assign index_o = hash_index_t'(hash_i[input_width_lp-1:bank_bits_lp]);

endmodule

//--- verilog/manycore_link_pkg.sv
`include "manycore_defines.svh"

package manycore_link_pkg;

  // one flit on the narrow link
  // head: {x, y, epa[27:18]}
  // tail: epa[17:0]
  typedef logic [`MC_FLIT_WIDTH-1:0] flit_t;

  // serializer fsm
  // SER_HEAD and SER_TAIL name the flit currently on the link
  typedef enum logic [1:0] {
    SER_IDLE = 2'd0,  // link quiet, waiting on fifo
    SER_HEAD = 2'd1,  // head flit driven
    SER_TAIL = 2'd2   // tail flit driven
  } ser_state_e;

endpackage

//--- verilog/manycore_addr_pkg.sv
`include "manycore_defines.svh"

package manycore_addr_pkg;

  // endpoint virtual address, byte granular
  typedef logic [`MC_DATA_WIDTH-1:0] eva_t;

  // endpoint physical address, word granular
  typedef logic [`MC_ADDR_WIDTH-1:0] epa_t;

  // mesh coordinates
  typedef logic [`MC_X_CORD_WIDTH-1:0] x_cord_t;
  typedef logic [`MC_Y_CORD_WIDTH-1:0] y_cord_t;

  // dram line address, eva bits 30 down to 5
  typedef logic [`MC_HASH_INPUT_WIDTH-1:0] hash_input_t;

  // bank select as {bottom_not_top, x}
  // only the low 3 bits carry information with 8 banks
  typedef logic [`MC_X_CORD_WIDTH-1:0] hash_bank_t;

  // line index inside one bank
  typedef logic [`MC_HASH_INDEX_WIDTH-1:0] hash_index_t;

endpackage

//--- include/manycore_defines.svh
`ifndef MANYCORE_DEFINES_SVH
`define MANYCORE_DEFINES_SVH

// datapath widths
`define MC_DATA_WIDTH    32   // eva, byte address
`define MC_ADDR_WIDTH    28   // epa, word address
`define MC_X_CORD_WIDTH  4
`define MC_Y_CORD_WIDTH  4

// mesh, one vcache bank above and one below each column
`define MC_NUM_TILES_X   4

// vcache geometry
`define MC_VCACHE_BLOCK_WORDS  8
`define MC_VCACHE_SIZE_WORDS   512
`define MC_VCACHE_SETS         64

`define MC_FIFO_DEPTH    4
`define MC_FLIT_WIDTH    18

// tile-group constants, fixed in hardware
`define MC_TG_DIM        4
`define MC_STRIPE_WORDS  8
`define MC_DMEM_BASE     16'h400  // word address of dmem[0]

// derived widths of the dram hash
`define MC_BLOCK_OFFSET_WIDTH  $clog2(`MC_VCACHE_BLOCK_WORDS)
`define MC_HASH_BANK_BITS      $clog2(2*`MC_NUM_TILES_X)
`define MC_HASH_INPUT_WIDTH    (`MC_DATA_WIDTH-3-`MC_BLOCK_OFFSET_WIDTH)
`define MC_HASH_INDEX_WIDTH    (`MC_HASH_INPUT_WIDTH-`MC_HASH_BANK_BITS)

`endif
